/* ad7794_adc.f */
common/ad7794_pkg.sv
spi_master/spi_master.sv
src/ad7794.sv
src/ad7794_sequencer.sv
src/sample_fifo.sv
src/ad7794_adc_top.sv
test/ad7794_slave_model.sv
test/ad7794_properties.sv
test/tb_ad7794_adc.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
	-f ad7794_adc.f --top-module tb_ad7794_adc -o sim_ad7794_adc
./obj_dir/sim_ad7794_adc +verilator+error+limit+1000 > sim.log 2>&1 || true
cat sim.log

if grep -q '\*\*\* FAILED \*\*\*' sim.log; then
	echo "simulation reported errors"
	exit 1
fi
if ! grep -q '\*\*\* PASSED \*\*\*' sim.log; then
	echo "simulation ended without a result"
	exit 1
fi
echo "simulation clean"

/* test/tb_ad7794_adc.sv */
`timescale 1ns/1ps

module tb_ad7794_adc;
	import ad7794_pkg::*;

	localparam int num_channels   = 3;
	localparam int sample_timeout = 4000;  // Clock cycles per awaited sample.

	logic        clkin  = 1'b0;
	logic        adcclk = 1'b0;
	logic        rst_n;
	logic        adc_clk;
	logic        cs;
	logic        din;
	logic        sclk;
	logic        dout_rdy;
	logic        sclk_in;
	logic        mosi_in;
	logic        ss_in;
	logic        miso_out;
	logic        spi_ssb_in;
	logic        spi_ssb_out;
	logic        sample_pop;
	logic        sample_valid;
	sample_t     sample_data;
	logic        overflow;
	logic [1:0]  busy_polls;
	int          protocol_errors;
	int          data_reads;
	logic [31:0] lcg_state = 32'hb40178b9;
	int          check_errors;
	int          timeouts;
	int          assert_fails;
	int          stop_reads;
	chan_t       exp_chan;
	int          conv_count [8];
	bit          ok;

	ad7794_adc_top #(
		.tsckhalf    (2),
		.num_channels(num_channels),
		.fifo_depth  (4),
		.spimode     ("chain")
	) DUT (.*);

	ad7794_slave_model u_model (.*);

	always #20 clkin = ~clkin;

	always @(posedge clkin) adcclk <= ~adcclk;  // ADC master clock at half rate.

	// ADC master clock and dout line pass straight through the wrapper.
	always @(negedge clkin) begin
		assert (adc_clk === adcclk) else begin
			$display("CHECK FAILED time=%0t signal=adc_clk expected=%b actual=%b",
				$time, adcclk, adc_clk);
			check_errors++;
		end
		assert (miso_out === dout_rdy) else begin
			$display("CHECK FAILED time=%0t signal=miso_out expected=%b actual=%b",
				$time, dout_rdy, miso_out);
			check_errors++;
		end
	end

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	task automatic wait_valid(output bit found);
		int n;
		found = 0;
		n = 0;
		busy_polls <= 2'(lcg_next() >> 30);  // Busy replies for a coming conversion.
		while (!found && n < sample_timeout) begin
			@(posedge clkin);
			found = sample_valid;
			n++;
		end
		if (!found) begin
			$display("TIMEOUT: no sample arrived within %0d cycles", sample_timeout);
			timeouts++;
		end
	endtask

	task automatic advance_prediction();
		conv_count[exp_chan]++;
		exp_chan = (exp_chan == chan_t'(num_channels - 1)) ? '0 : exp_chan + 3'd1;
	endtask

	task automatic check_head();
		sample_t expected;
		expected = {exp_chan, 24'h100000 + 24'(exp_chan) * 24'h010000 + 24'(conv_count[exp_chan])};
		assert (sample_data == expected) else begin
			$display("CHECK FAILED time=%0t signal=sample_data expected=%h actual=%h",
				$time, expected, sample_data);
			check_errors++;
		end
		advance_prediction();
	endtask

	task automatic pop_head();
		sample_pop <= 1'b1;
		@(posedge clkin);
		sample_pop <= 1'b0;
	endtask

	// Waits for cs to reach a level, then returns on the next clock.
	task automatic wait_cs(input logic level, input string what);
		int n;
		n = 0;
		while (cs !== level && n < sample_timeout) begin
			@(posedge clkin);
			n++;
		end
		if (cs !== level) begin
			$display("TIMEOUT: %s", what);
			timeouts++;
		end
	endtask

	// Host takes the bus in the short gap after a frame ends.
	task automatic host_bus_window();
		wait_cs(1'b0, "no frame started before the host window");
		wait_cs(1'b1, "frame did not end before the host window");
		spi_ssb_in <= 1'b0;
		sclk_in    <= 1'b0;
		mosi_in    <= 1'b1;
		@(posedge clkin);
		sclk_in <= 1'b1;
		mosi_in <= 1'b0;
		@(posedge clkin);
		spi_ssb_in <= 1'b1;
	endtask

	task automatic wait_overflow();
		int n;
		n = 0;
		while (!overflow && n < 8 * sample_timeout) begin
			@(posedge clkin);
			n++;
		end
		if (!overflow) begin
			$display("TIMEOUT: overflow never set while the host was idle");
			timeouts++;
		end
	endtask

	// ==================================================
	// Main sequence
	// ==================================================
	initial begin
		rst_n        = 1'b0;
		sclk_in      = 1'b1;
		mosi_in      = 1'b0;
		ss_in        = 1'b1;
		spi_ssb_in   = 1'b1;
		sample_pop   = 1'b0;
		busy_polls   = 2'd0;
		check_errors = 0;
		timeouts     = 0;
		exp_chan     = '0;
		foreach (conv_count[i]) conv_count[i] = 0;
		repeat (10) @(posedge clkin);
		rst_n <= 1'b1;
		wait_cs(1'b0, "no SPI frame after reset release");

		for (int i = 0; i < 9 && timeouts == 0; i++) begin
			wait_valid(ok);
			if (ok) begin
				repeat (lcg_next() >> 29) @(posedge clkin);  // Random host pop gap.
				check_head();
				pop_head();
			end
			if (i == 2) host_bus_window();
		end

		// Host goes idle with the FIFO empty. Four samples fit, the fifth is lost.
		stop_reads = data_reads;
		if (timeouts == 0) wait_overflow();
		if (timeouts == 0) begin
			assert (data_reads - stop_reads == 5) else begin
				$display("CHECK FAILED time=%0t signal=overflow expected=set on sample 5 actual=%0d",
					$time, data_reads - stop_reads);
				check_errors++;
			end
			for (int j = 0; j < 4 && timeouts == 0; j++) begin
				wait_valid(ok);
				if (ok) begin
					check_head();
					pop_head();
				end
			end
			advance_prediction();  // The dropped sample.
		end

		assert_fails = DUT.u_props.reset_fails + DUT.u_props.frame_fails +
			DUT.u_props.idle_fails + DUT.u_props.chain_fails;
		$display("errors: checks=%0d protocol=%0d assertions=%0d timeouts=%0d",
			check_errors, protocol_errors, assert_fails, timeouts);
		if (check_errors + protocol_errors + assert_fails + timeouts == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

endmodule

/* test/ad7794_properties.sv */
`timescale 1ns/1ps

module ad7794_properties (
	input logic clkin,
	input logic rst_n,
	input logic cs,
	input logic sclk,
	input logic din,
	input logic sclk_in,
	input logic mosi_in,
	input logic spi_ssb_in,
	input logic spi_ssb_out,
	input logic sample_valid,
	input logic overflow
);
	logic       rst_q;
	logic       cs_q;
	logic       sclk_q;
	logic [6:0] rise_cnt;  // Sclk rising edges in the current cs window.
	int         reset_fails = 0;
	int         frame_fails = 0;
	int         idle_fails  = 0;
	int         chain_fails = 0;

	always_ff @(posedge clkin or negedge rst_n) begin
		if (!rst_n) begin
			rst_q    <= 1'b0;
			cs_q     <= 1'b1;
			sclk_q   <= 1'b1;
			rise_cnt <= '0;
		end else begin
			rst_q  <= 1'b1;
			cs_q   <= cs;
			sclk_q <= sclk;
			if (!cs && sclk && !sclk_q) rise_cnt <= rise_cnt + 7'd1;
			else if (cs && cs_q) rise_cnt <= '0;
		end
	end

	// ==================================================
	// Reset state, framing and chain muxing
	// ==================================================
	a_reset_state: assert property (@(posedge clkin) (rst_n && !rst_q) |->
		(cs && sclk && spi_ssb_out && !sample_valid && !overflow))
		else begin
			$error("pins or flags wrong at reset release");
			reset_fails++;
		end

	a_frame_len: assert property (@(posedge clkin) disable iff (!rst_n)
		(cs && !cs_q) |-> (rise_cnt == 7'd32))
		else begin
			$error("cs window without 32 sclk edges");
			frame_fails++;
		end

	a_sclk_idle: assert property (@(posedge clkin) disable iff (!rst_n)
		(cs && spi_ssb_in) |-> sclk)
		else begin
			$error("sclk low while cs high");
			idle_fails++;
		end

	a_chain_mux: assert property (@(posedge clkin) disable iff (!rst_n)
		!spi_ssb_in |-> (sclk == sclk_in && din == mosi_in))
		else begin
			$error("host pins not routed in chain mode");
			chain_fails++;
		end

endmodule

bind ad7794_adc_top ad7794_properties u_props (
	.clkin       (clkin),
	.rst_n       (rst_n),
	.cs          (cs),
	.sclk        (sclk),
	.din         (din),
	.sclk_in     (sclk_in),
	.mosi_in     (mosi_in),
	.spi_ssb_in  (spi_ssb_in),
	.spi_ssb_out (spi_ssb_out),
	.sample_valid(sample_valid),
	.overflow    (overflow)
);

/* test/ad7794_slave_model.sv */
`timescale 1ns/1ps

module ad7794_slave_model (
	input  logic       cs,
	input  logic       sclk,
	input  logic       din,
	output logic       dout_rdy,
	input  logic [1:0] busy_polls,
	output int         protocol_errors,
	output int         data_reads
);
	import ad7794_pkg::*;

	logic [31:0] frame;       // Bits shifted in this frame.
	logic [23:0] out_word;    // Readback for the data phase.
	logic        rd;
	logic [2:0]  rs;
	int          bit_cnt;
	int          phase;       // 0 config, 1 mode, 2 converting, 3 ready.
	int          polls_left;  // Busy status replies still to give.
	chan_t       chan;
	int          conv_count [8];

	initial begin
		dout_rdy        = 1'b1;
		protocol_errors = 0;
		data_reads      = 0;
		frame           = '0;
		out_word        = '0;
		rd              = 1'b0;
		rs              = '0;
		bit_cnt         = 0;
		phase           = 0;
		polls_left      = 0;
		chan            = '0;
		foreach (conv_count[i]) conv_count[i] = 0;
	end

	task automatic flag_error(input string what);
		$display("ERROR: %s at %0t", what, $time);
		protocol_errors++;
	endtask

	// ==================================================
	// Command byte and register order
	// ==================================================
	task automatic decode_command();
		logic ok;
		if (frame[7]) flag_error($sformatf("command byte %h has write enable set", frame[7:0]));
		rd = frame[6];
		rs = frame[5:3];
		case (phase)
			0:       ok = !rd && (rs == REG_CONFIG);
			1:       ok = !rd && (rs == REG_MODE);
			2:       ok = rd && (rs == REG_STATUS);
			default: ok = rd && (rs == REG_DATA);
		endcase
		if (phase == 2 && rd && rs == REG_DATA) begin
			flag_error("data register read while RDY is still high");
		end else if (!ok) begin
			flag_error($sformatf("register %0d accessed out of order in phase %0d", rs, phase));
		end
		if (rd && rs == REG_STATUS) begin
			out_word = {polls_left != 0, 4'b0000, chan, 16'h0000};  // RDY on bit 7.
		end else if (rd && rs == REG_DATA) begin
			out_word = 24'h100000 + 24'(chan) * 24'h010000 + 24'(conv_count[chan]);
		end else begin
			out_word = '0;
		end
	endtask

	task automatic close_frame();
		bit_cnt = 0;
		if (!rd && rs == REG_CONFIG) begin
			chan  = chan_t'(frame[10:8]);  // Channel in the config low bits.
			phase = 1;
		end else if (!rd && rs == REG_MODE) begin
			polls_left = int'(busy_polls);  // Conversion starts.
			phase      = 2;
		end else if (rd && rs == REG_STATUS) begin
			if (polls_left == 0) phase = 3;
			else polls_left--;
		end else if (rd && rs == REG_DATA) begin
			conv_count[chan]++;
			data_reads++;
			phase = 0;
		end
	endtask

	// Din sampled on rising sclk, dout driven on falling sclk.
	always @(posedge sclk) begin
		if (!cs) begin
			frame = {frame[30:0], din};
			bit_cnt++;
			if (bit_cnt == 8) decode_command();
			else if (bit_cnt == 32) close_frame();
		end
	end

	always @(negedge sclk) begin
		if (!cs) begin
			dout_rdy = (rd && bit_cnt >= 8) ? out_word[31 - bit_cnt] : 1'b1;
		end
	end

endmodule

/* src/ad7794_adc_top.sv */
`timescale 1ns/1ps

module ad7794_adc_top #(
	parameter int    tsckhalf     = 16,
	parameter int    num_channels = 6,
	parameter int    fifo_depth   = 8,
	parameter string spimode      = "standalone"
) (
	input  logic                clkin,
	input  logic                rst_n,
	input  logic                adcclk,
	output logic                adc_clk,
	output logic                cs,
	output logic                din,
	output logic                sclk,
	input  logic                dout_rdy,
	input  logic                sclk_in,
	input  logic                mosi_in,
	input  logic                ss_in,
	output logic                miso_out,
	input  logic                spi_ssb_in,
	output logic                spi_ssb_out,
	input  logic                sample_pop,
	output logic                sample_valid,
	output ad7794_pkg::sample_t sample_data,
	output logic                overflow
);
	import ad7794_pkg::*;

	// ==================================================
	// Command path and sample path
	// ==================================================
	logic      spi_start;
	logic      spi_busy;
	logic      spi_read;
	spi_cmd_t  spi_addr;
	adc_code_t spi_data;
	adc_code_t spi_rdbk;
	logic      spi_ready;
	logic      sample_push;
	sample_t   sample_in;

	ad7794 #(
		.tsckhalf(tsckhalf),
		.spimode (spimode)
	) u_adc (
		.clkin      (clkin),
		.rst_n      (rst_n),
		.adcclk     (adcclk),
		.adc_clk    (adc_clk),
		.cs         (cs),
		.din        (din),
		.sclk       (sclk),
		.dout_rdy   (dout_rdy),
		.sclk_in    (sclk_in),
		.mosi_in    (mosi_in),
		.ss_in      (ss_in),
		.miso_out   (miso_out),
		.spi_ssb_in (spi_ssb_in),
		.spi_ssb_out(spi_ssb_out),
		.spi_start  (spi_start),
		.spi_busy   (spi_busy),
		.spi_read   (spi_read),
		.spi_addr   (spi_addr),
		.spi_data   (spi_data),
		.spi_rdbk   (spi_rdbk),
		.spi_ready  (spi_ready)
	);

	ad7794_sequencer #(
		.num_channels(num_channels)
	) u_seq (
		.clkin      (clkin),
		.rst_n      (rst_n),
		.spi_start  (spi_start),
		.spi_busy   (spi_busy),
		.spi_read   (spi_read),
		.spi_addr   (spi_addr),
		.spi_data   (spi_data),
		.spi_rdbk   (spi_rdbk),
		.spi_ready  (spi_ready),
		.sample_push(sample_push),
		.sample_in  (sample_in)
	);

	sample_fifo #(
		.fifo_depth(fifo_depth)
	) u_fifo (
		.clkin       (clkin),
		.rst_n       (rst_n),
		.sample_push (sample_push),
		.sample_in   (sample_in),
		.sample_pop  (sample_pop),
		.sample_valid(sample_valid),
		.sample_data (sample_data),
		.overflow    (overflow)
	);

endmodule

/* src/sample_fifo.sv */
`timescale 1ns/1ps

module sample_fifo #(
	parameter int fifo_depth = 8
) (
	input  logic                clkin,
	input  logic                rst_n,
	input  logic                sample_push,
	input  ad7794_pkg::sample_t sample_in,
	input  logic                sample_pop,
	output logic                sample_valid,
	output ad7794_pkg::sample_t sample_data,
	output logic                overflow
);
	import ad7794_pkg::*;

	localparam int aw = $clog2(fifo_depth);

	sample_t       mem [fifo_depth];
	logic [aw:0]   wr_ptr;   // Extra bit tells full from empty.
	logic [aw:0]   rd_ptr;
	logic          full;
	logic          wr_en;
	logic          rd_en;

	assign full         = (wr_ptr[aw] != rd_ptr[aw]) && (wr_ptr[aw-1:0] == rd_ptr[aw-1:0]);
	assign sample_valid = (wr_ptr != rd_ptr);
	assign sample_data  = mem[rd_ptr[aw-1:0]];  // Head shows without a pop.
	assign wr_en        = sample_push && !full;
	assign rd_en        = sample_pop && sample_valid;

	// ==================================================
	// Pointers and overflow
	// ==================================================
	always_ff @(posedge clkin or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr   <= '0;
			rd_ptr   <= '0;
			overflow <= 1'b0;
		end else begin
			if (wr_en) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (rd_en) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			if (sample_push && full) begin
				overflow <= 1'b1;  // Sticky until reset.
			end
		end
	end

	always_ff @(posedge clkin) begin
		if (wr_en) begin
			mem[wr_ptr[aw-1:0]] <= sample_in;
		end
	end

endmodule

/* src/ad7794_sequencer.sv */
`timescale 1ns/1ps

module ad7794_sequencer #(
	parameter int num_channels = 4
) (
	input  logic                  clkin,
	input  logic                  rst_n,
	output logic                  spi_start,
	input  logic                  spi_busy,
	output logic                  spi_read,
	output ad7794_pkg::spi_cmd_t  spi_addr,
	output ad7794_pkg::adc_code_t spi_data,
	input  ad7794_pkg::adc_code_t spi_rdbk,
	input  logic                  spi_ready,
	output logic                  sample_push,
	output ad7794_pkg::sample_t   sample_in
);
	import ad7794_pkg::*;

	localparam int rdy_idx = $bits(adc_code_t) - 8 + STATUS_RDY_BIT;  // Status byte on top.

	typedef enum logic [2:0] {
		S_CFG_ISSUE,
		S_CFG_WAIT,
		S_MODE_ISSUE,
		S_MODE_WAIT,
		S_STAT_ISSUE,
		S_STAT_WAIT,
		S_DATA_ISSUE,
		S_DATA_WAIT
	} seq_state_t;

	seq_state_t state;
	chan_t      chan;   // Channel being converted.
	logic       issue;

	assign issue = !spi_busy;

	// ==================================================
	// Register sequence per channel
	// ==================================================
	always_ff @(posedge clkin or negedge rst_n) begin
		if (!rst_n) begin
			state       <= S_CFG_ISSUE;
			chan        <= '0;
			spi_start   <= 1'b0;
			sample_push <= 1'b0;
		end else begin
			spi_start   <= 1'b0;
			sample_push <= 1'b0;
			case (state)
				S_CFG_ISSUE, S_MODE_ISSUE, S_STAT_ISSUE, S_DATA_ISSUE: begin
					if (issue) begin
						spi_start <= 1'b1;
						state     <= seq_state_t'(state + 3'd1);  // Matching wait state.
					end
				end
				S_CFG_WAIT: if (spi_ready) state <= S_MODE_ISSUE;
				S_MODE_WAIT: if (spi_ready) state <= S_STAT_ISSUE;
				S_STAT_WAIT: begin
					if (spi_ready) begin
						// Poll again until RDY drops.
						state <= spi_rdbk[rdy_idx] ? S_STAT_ISSUE : S_DATA_ISSUE;
					end
				end
				S_DATA_WAIT: begin
					if (spi_ready) begin
						sample_push <= 1'b1;
						state       <= S_CFG_ISSUE;
						chan        <= (chan == chan_t'(num_channels - 1)) ? '0 : chan + 3'd1;
					end
				end
				default: state <= S_CFG_ISSUE;
			endcase
		end
	end

	// Command words, valid alongside spi_start.
	always_ff @(posedge clkin) begin
		case (state)
			S_CFG_ISSUE: begin
				spi_read <= 1'b0;
				spi_addr <= make_cmd(1'b0, REG_CONFIG);
				spi_data <= {CFG_BASE + 16'(chan), 8'h00};  // Left aligned.
			end
			S_MODE_ISSUE: begin
				spi_read <= 1'b0;
				spi_addr <= make_cmd(1'b0, REG_MODE);
				spi_data <= {MODE_SINGLE, 8'h00};
			end
			S_STAT_ISSUE: begin
				spi_read <= 1'b1;
				spi_addr <= make_cmd(1'b1, REG_STATUS);
				spi_data <= '0;
			end
			S_DATA_ISSUE: begin
				spi_read <= 1'b1;
				spi_addr <= make_cmd(1'b1, REG_DATA);
				spi_data <= '0;
			end
			S_DATA_WAIT: begin
				if (spi_ready) begin
					sample_in <= {chan, spi_rdbk};  // Tag with the channel.
				end
			end
			default: ;
		endcase
	end

endmodule

/* src/ad7794.sv */
`timescale 1ns/1ps

module ad7794 #(
	parameter int    tsckhalf = 16,
	parameter string spimode  = "standalone"
) (
	input  logic                  clkin,
	input  logic                  rst_n,
	input  logic                  adcclk,
	output logic                  adc_clk,
	output logic                  cs,
	output logic                  din,
	output logic                  sclk,
	input  logic                  dout_rdy,
	input  logic                  sclk_in,
	input  logic                  mosi_in,
	input  logic                  ss_in,
	output logic                  miso_out,
	input  logic                  spi_ssb_in,
	output logic                  spi_ssb_out,
	input  logic                  spi_start,
	output logic                  spi_busy,
	input  logic                  spi_read,
	input  ad7794_pkg::spi_cmd_t  spi_addr,
	input  ad7794_pkg::adc_code_t spi_data,
	output ad7794_pkg::adc_code_t spi_rdbk,
	output logic                  spi_ready
);
	logic eng_cs;
	logic eng_sck;
	logic eng_sdi;

	assign adc_clk     = adcclk;          // Master clock for the ADC.
	assign miso_out    = dout_rdy;        // Shared dout line back to the host.
	assign spi_ssb_out = spi_ssb_in & cs;

	// ==================================================
	// Pin routing per bus mode
	// ==================================================
	generate
		if (spimode == "passthrough") begin : g_pass
			assign sclk = sclk_in;
			assign din  = mosi_in;
			assign cs   = ss_in;
		end else if (spimode == "chain") begin : g_chain
			assign sclk = spi_ssb_in ? eng_sck : sclk_in;  // Host owns sclk while ssb low.
			assign din  = spi_ssb_in ? eng_sdi : mosi_in;
			assign cs   = eng_cs;
		end else begin : g_alone
			assign sclk = eng_sck;
			assign din  = eng_sdi;
			assign cs   = eng_cs;
		end
	endgenerate

	spi_master #(
		.tsckhalf(tsckhalf)
	) u_spi (
		.clkin    (clkin),
		.rst_n    (rst_n),
		.spi_start(spi_start),
		.spi_busy (spi_busy),
		.spi_read (spi_read),
		.spi_addr (spi_addr),
		.spi_data (spi_data),
		.spi_rdbk (spi_rdbk),
		.spi_ready(spi_ready),
		.cs       (eng_cs),
		.sck      (eng_sck),
		.sdi      (eng_sdi),
		.sdo      (dout_rdy)
	);

endmodule

/* spi_master/spi_master.sv */
`timescale 1ns/1ps

module spi_master #(
	parameter int tsckhalf = 16
) (
	input  logic                  clkin,
	input  logic                  rst_n,
	input  logic                  spi_start,
	output logic                  spi_busy,
	input  logic                  spi_read,
	input  ad7794_pkg::spi_cmd_t  spi_addr,
	input  ad7794_pkg::adc_code_t spi_data,
	output ad7794_pkg::adc_code_t spi_rdbk,
	output logic                  spi_ready,
	output logic                  cs,
	output logic                  sck,
	output logic                  sdi,
	input  logic                  sdo
);
	import ad7794_pkg::*;

	localparam int frame_bits = $bits(spi_cmd_t) + $bits(adc_code_t);
	localparam int cnt_w = $clog2(tsckhalf) + 1;

	logic [cnt_w-1:0]      half_cnt;  // Clocks within one sclk half period.
	logic [5:0]            bit_cnt;   // Rising edges seen in this frame.
	logic [frame_bits-1:0] shreg;     // Command and data out, readback in.
	logic                  done;      // Frame closed, readback pending.
	logic                  tick;
	logic                  rise;
	logic                  frame_end;

	assign tick      = spi_busy && !cs && (half_cnt == cnt_w'(tsckhalf - 1));
	assign rise      = tick && !sck;
	assign frame_end = tick && sck && (bit_cnt == 6'(frame_bits));

	// ==================================================
	// Framing and sclk generation
	// ==================================================
	always_ff @(posedge clkin or negedge rst_n) begin
		if (!rst_n) begin
			spi_busy  <= 1'b0;
			spi_ready <= 1'b0;
			done      <= 1'b0;
			cs        <= 1'b1;
			sck       <= 1'b1;
			sdi       <= 1'b1;
			half_cnt  <= '0;
			bit_cnt   <= '0;
		end else begin
			spi_ready <= done;       // One cycle after cs rises.
			done      <= frame_end;
			if (spi_ready) begin
				spi_busy <= 1'b0;    // Busy covers the ready cycle.
			end else if (spi_start && !spi_busy) begin
				spi_busy <= 1'b1;
				cs       <= 1'b0;
				half_cnt <= '0;
				bit_cnt  <= '0;
			end
			if (spi_busy && !cs) begin
				if (tick) begin
					half_cnt <= '0;
					if (frame_end) begin
						cs  <= 1'b1;
						sdi <= 1'b1;
					end else if (sck) begin
						sck <= 1'b0;                 // Falling edge, next bit out.
						sdi <= shreg[frame_bits-1];
					end else begin
						sck     <= 1'b1;             // Rising edge, ADC samples din.
						bit_cnt <= bit_cnt + 6'd1;
					end
				end else begin
					half_cnt <= half_cnt + 1'b1;
				end
			end
		end
	end

	// ==================================================
	// Shift register and readback
	// ==================================================
	always_ff @(posedge clkin) begin
		if (spi_start && !spi_busy) begin
			// Reads send zeros in the data phase.
			shreg <= {spi_addr, spi_read ? adc_code_t'('0) : spi_data};
		end else if (rise) begin
			shreg <= {shreg[frame_bits-2:0], sdo};  // Dout sampled with sclk rising.
		end
		if (done) begin
			spi_rdbk <= shreg[$bits(adc_code_t)-1:0];
		end
	end

endmodule

/* common/ad7794_pkg.sv */
package ad7794_pkg;

	// ==================================================
	// Data widths
	// ==================================================
	typedef logic [23:0] adc_code_t;  // Conversion result or data phase word.
	typedef logic [7:0]  spi_cmd_t;   // Communications register byte.
	typedef logic [2:0]  chan_t;      // Input channel number.
	typedef logic [26:0] sample_t;    // Channel tag above the code.

	// ==================================================
	// Register map
	// ==================================================
	localparam logic [2:0] REG_STATUS = 3'd0;
	localparam logic [2:0] REG_MODE   = 3'd1;
	localparam logic [2:0] REG_CONFIG = 3'd2;
	localparam logic [2:0] REG_DATA   = 3'd3;

	localparam logic [15:0] MODE_SINGLE = 16'h200a;  // Single conversion, 16.7 Hz filter.
	localparam logic [15:0] CFG_BASE    = 16'h0010;  // Buffered input, channel in bits 3:0.

	localparam int STATUS_RDY_BIT = 7;  // Low once a conversion is done.

	// Builds the communications byte, WEN kept low so the write is accepted.
	function automatic spi_cmd_t make_cmd(input logic rd, input logic [2:0] rs);
		return {1'b0, rd, rs, 3'b000};
	endfunction

endpackage
